// File: Makefile
TOP = tb_synth_core

.PHONY: all compile run clean

all: run

# Builds the simulation binary from the file list
compile:
	verilator --binary --timing --assert -Wno-fatal \
		-f synth_core.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

# A $fatal in the testbench ends the binary with a non-zero status
run: compile
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// File: config_write_decoder.sv
`timescale 1ns/100ps

`include "synth_cfg.svh"

module config_write_decoder (
    input logic i_Clock,
    input logic i_arst_n,

    input logic i_ConfigWrite,
    input logic [`CFG_ADDR_WIDTH-1:0] i_ConfigAddr,
    input logic [15:0] i_ConfigData,

    output logic o_PhaseStepWriteEnable,
    output logic o_LevelWriteEnable,
    output logic [1:0] o_NoteOnWriteEnable,
    output synth_pkg::voice_operator_t o_ConfigWriteAddr,
    output logic [15:0] o_ConfigWriteData
);

// Target space sits in the two top address bits
logic [1:0] w_AddrSpace;
logic w_NoteOnSelectHigh;

assign w_AddrSpace = i_ConfigAddr[`CFG_ADDR_WIDTH-1 -: 2];

// For the note-on space bit 0 picks the upper half of the 32 bits
assign w_NoteOnSelectHigh = i_ConfigAddr[0];

// ------------------------------------------------------------
// Write register, one clock between the strobe and the stages
// ------------------------------------------------------------
always_ff @(posedge i_Clock) begin
    o_PhaseStepWriteEnable <= i_ConfigWrite && (w_AddrSpace == 2'b00);
    o_LevelWriteEnable <= i_ConfigWrite && (w_AddrSpace == 2'b01);

    // Space 11 falls through every compare and raises nothing
    o_NoteOnWriteEnable[1] <= i_ConfigWrite && (w_AddrSpace == 2'b10) && w_NoteOnSelectHigh;
    o_NoteOnWriteEnable[0] <= i_ConfigWrite && (w_AddrSpace == 2'b10) && !w_NoteOnSelectHigh;

    // Memory index is the low voice-operator field of the address
    o_ConfigWriteAddr <= synth_pkg::voice_operator_t'(i_ConfigAddr);
    o_ConfigWriteData <= i_ConfigData;
end

// A single write may only land in one memory of one stage
a_one_target : assert property (
    @(posedge i_Clock) disable iff (!i_arst_n)
    $onehot0({o_PhaseStepWriteEnable, o_LevelWriteEnable, o_NoteOnWriteEnable})
);

endmodule

// File: operator_sequencer.sv
`timescale 1ns/100ps

`include "synth_cfg.svh"

module operator_sequencer (
    input logic i_Clock,
    input logic i_arst_n,

    output synth_pkg::voice_operator_t o_VoiceOperator,
    output logic o_Valid
);

// The valid flag rises on the first clock after reset and the counter
// only moves once it is set, so id 0 is issued as the first valid id
always_ff @(posedge i_Clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
        o_Valid <= 1'b0;
    end else begin
        o_Valid <= 1'b1;
    end
end

// Ids go 0 to 127 and wrap, one per clock
always_ff @(posedge i_Clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
        o_VoiceOperator <= '0;
    end else if (o_Valid) begin
        o_VoiceOperator <= o_VoiceOperator + 1'b1;
    end
end

// Back-to-back valid ids must be consecutive, the mixer and the
// phase feedback both rely on that order
a_id_steps_by_one : assert property (
    @(posedge i_Clock) disable iff (!i_arst_n)
    o_Valid && $past(o_Valid)
        |-> o_VoiceOperator == synth_pkg::voice_operator_t'($past(o_VoiceOperator) + 1'b1)
);

endmodule

// File: stage_phase_accumulator.sv
`timescale 1ns/100ps

`include "synth_cfg.svh"

module stage_phase_accumulator (
    input logic i_Clock,
    input logic i_arst_n,

    output synth_pkg::phase_t o_Phase,

    input synth_pkg::voice_operator_t i_VoiceOperator,
    output synth_pkg::voice_operator_t o_VoiceOperator,
    input logic i_Valid,
    output logic o_Valid,

    output logic o_NoteOn,

    input logic [1:0] i_NoteOnConfigWriteEnable,
    input logic i_PhaseStepConfigWriteEnable,
    input synth_pkg::voice_operator_t i_ConfigWriteAddr,
    input logic [15:0] i_ConfigWriteData
);

// Phase is unsigned so that overflow simply wraps to the next period
synth_pkg::phase_t r_PhaseAccumulators [`NUM_VOICE_OPERATORS];
synth_pkg::phase_t r_PhaseStepConfig [`NUM_VOICE_OPERATORS];

// One note-on bit per voice, shared by its four operators
logic [`NUM_VOICES-1:0] r_NoteOnConfig;

// Clock 1 pipeline registers
synth_pkg::voice_operator_t r_VoiceOperator;
synth_pkg::phase_t r_AccumulatedPhase;
synth_pkg::phase_t r_PhaseStep;
logic r_NoteOn;
logic r_Valid;

synth_pkg::phase_t w_SteppedPhase;

initial begin
    r_NoteOnConfig = '0;
    for (int i = 0; i < `NUM_VOICE_OPERATORS; i++) begin
        r_PhaseAccumulators[i] = '0;
        r_PhaseStepConfig[i] = '0;
    end
end

// Wraps at 16 bits, which is what makes the step a frequency
assign w_SteppedPhase = r_AccumulatedPhase + r_PhaseStep;

always_ff @(posedge i_Clock) begin
    if (i_PhaseStepConfigWriteEnable)
        r_PhaseStepConfig[i_ConfigWriteAddr] <= i_ConfigWriteData;

    if (i_NoteOnConfigWriteEnable[1])
        r_NoteOnConfig[`NUM_VOICES-1:`NUM_VOICES/2] <= i_ConfigWriteData;
    if (i_NoteOnConfigWriteEnable[0])
        r_NoteOnConfig[`NUM_VOICES/2-1:0] <= i_ConfigWriteData;

    // Clock 1
    // ------------------------------------------------------------
    // Clock 2 result goes back into the memory here. Only real ids
    // write, so the fill cycles leave operator 0 alone
    if (r_Valid)
        r_PhaseAccumulators[r_VoiceOperator] <= w_SteppedPhase;

    r_AccumulatedPhase <= r_PhaseAccumulators[i_VoiceOperator];
    r_PhaseStep <= r_PhaseStepConfig[i_VoiceOperator];
    r_NoteOn <= r_NoteOnConfig[synth_pkg::get_voice_id(i_VoiceOperator)];
    r_VoiceOperator <= i_VoiceOperator;

    // Clock 2
    // ------------------------------------------------------------
    o_Phase <= w_SteppedPhase;
    o_NoteOn <= r_NoteOn;
    o_VoiceOperator <= r_VoiceOperator;
end

// Valid follows the data through both clocks
always_ff @(posedge i_Clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
        r_Valid <= 1'b0;
        o_Valid <= 1'b0;
    end else begin
        r_Valid <= i_Valid;
        o_Valid <= r_Valid;
    end
end

endmodule

// File: stage_voice_mixer.sv
`timescale 1ns/100ps

`include "synth_cfg.svh"

module stage_voice_mixer (
    input logic i_Clock,
    input logic i_arst_n,

    input synth_pkg::sample_t i_Sample,
    input synth_pkg::voice_operator_t i_VoiceOperator,
    input logic i_Valid,

    output synth_pkg::mix_t o_VoiceSample,
    output synth_pkg::voice_t o_VoiceId,
    output logic o_SampleValid
);

localparam int OP_BITS = $clog2(`OPS_PER_VOICE);
localparam logic [OP_BITS-1:0] LAST_OP = OP_BITS'(`OPS_PER_VOICE - 1);

// Operator part of the incoming id
logic [OP_BITS-1:0] w_Operator;

// Sign-extended sample and the sum including it
synth_pkg::mix_t w_Sample;
synth_pkg::mix_t w_Total;

// Running sum of operators 0 up to the one before the current
synth_pkg::mix_t r_RunningSum;

assign w_Operator = i_VoiceOperator[OP_BITS-1:0];
assign w_Sample = synth_pkg::mix_t'(i_Sample);

// Operator 0 starts a new voice, so the old sum is dropped
assign w_Total = (w_Operator == '0) ? w_Sample : r_RunningSum + w_Sample;

always_ff @(posedge i_Clock) begin
    if (i_Valid)
        r_RunningSum <= w_Total;

    // Voice result and its id, captured with the last operator
    if (i_Valid && w_Operator == LAST_OP) begin
        o_VoiceSample <= w_Total;
        o_VoiceId <= synth_pkg::get_voice_id(i_VoiceOperator);
    end
end

// One pulse per voice, every fourth clock once the pipeline is full
always_ff @(posedge i_Clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
        o_SampleValid <= 1'b0;
    end else begin
        o_SampleValid <= i_Valid && (w_Operator == LAST_OP);
    end
end

// Ids arrive in order, so two voices never end on adjacent clocks
a_no_back_to_back : assert property (
    @(posedge i_Clock) disable iff (!i_arst_n)
    o_SampleValid |=> !o_SampleValid
);

endmodule

// File: stage_waveform.sv
`timescale 1ns/100ps

`include "synth_cfg.svh"

module stage_waveform (
    input logic i_Clock,
    input logic i_arst_n,

    input synth_pkg::phase_t i_Phase,
    input logic i_NoteOn,
    input synth_pkg::voice_operator_t i_VoiceOperator,
    input logic i_Valid,

    input logic i_LevelWriteEnable,
    input synth_pkg::voice_operator_t i_ConfigWriteAddr,
    input logic [15:0] i_ConfigWriteData,

    output synth_pkg::sample_t o_Sample,
    output synth_pkg::voice_operator_t o_VoiceOperator,
    output logic o_Valid
);

localparam int SINE_ENTRIES = 1 << `SINE_INDEX_WIDTH;
localparam real PI = 3.14159265358979;

// One full period of the sine, peak 32767
synth_pkg::sample_t r_SineTable [SINE_ENTRIES];

// Per-operator output level
synth_pkg::level_t r_LevelConfig [`NUM_VOICE_OPERATORS];

logic [`SINE_INDEX_WIDTH-1:0] w_SineIndex;
synth_pkg::sample_t w_SineValue;

// Signed sample times unsigned level, with a zero sign bit on the level
logic signed [`SAMPLE_WIDTH+`LEVEL_WIDTH:0] w_Product;

initial begin
    real angle;
    // int'() rounds to the nearest integer
    for (int i = 0; i < SINE_ENTRIES; i++) begin
        angle = 2.0 * PI * real'(i) / real'(SINE_ENTRIES);
        r_SineTable[i] = synth_pkg::sample_t'(int'(32767.0 * $sin(angle)));
    end
    for (int i = 0; i < `NUM_VOICE_OPERATORS; i++) begin
        r_LevelConfig[i] = '0;
    end
end

always_ff @(posedge i_Clock) begin
    if (i_LevelWriteEnable)
        r_LevelConfig[i_ConfigWriteAddr] <= i_ConfigWriteData[`LEVEL_WIDTH-1:0];
end

// Top phase bits pick the table entry, the rest are dropped
assign w_SineIndex = i_Phase[`PHASE_WIDTH-1 -: `SINE_INDEX_WIDTH];
assign w_SineValue = r_SineTable[w_SineIndex];
assign w_Product = w_SineValue * $signed({1'b0, r_LevelConfig[i_VoiceOperator]});

// ------------------------------------------------------------
// Output register, the shift floors toward minus infinity
// ------------------------------------------------------------
always_ff @(posedge i_Clock) begin
    if (i_NoteOn)
        o_Sample <= synth_pkg::sample_t'(w_Product >>> `LEVEL_WIDTH);
    else
        o_Sample <= '0;
    o_VoiceOperator <= i_VoiceOperator;
end

always_ff @(posedge i_Clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
        o_Valid <= 1'b0;
    end else begin
        o_Valid <= i_Valid;
    end
end

endmodule

// File: synth_cfg.svh
`ifndef SYNTH_CFG_SVH
`define SYNTH_CFG_SVH

// Voice layout of the operator core
`define NUM_VOICES 32
`define OPS_PER_VOICE 4
`define NUM_VOICE_OPERATORS 128

// Bit range of a voice-operator id, voice in the upper bits and operator in the lower
`define VOICE_OPERATOR_ID [6:0]

// Phase accumulators wrap at this width, which sets the frequency resolution
`define PHASE_WIDTH 16

// Upper phase bits used to index the sine table, 1024 entries
`define SINE_INDEX_WIDTH 10

// Signed operator sample and unsigned operator level
`define SAMPLE_WIDTH 16
`define LEVEL_WIDTH 8

// Four 16-bit samples need two extra bits of headroom
`define MIX_WIDTH 18

// Register address, two bits of target space above the voice-operator index
`define CFG_ADDR_WIDTH 9

`endif

// File: synth_core.f
+incdir+.
synth_pkg.sv
operator_sequencer.sv
config_write_decoder.sv
stage_phase_accumulator.sv
stage_waveform.sv
stage_voice_mixer.sv
synth_core.sv
tb_synth_core.sv

// File: synth_core.sv
`timescale 1ns/100ps

`include "synth_cfg.svh"

module synth_core (
    input logic i_Clock,
    input logic i_arst_n,

    input logic i_ConfigWrite,
    input logic [`CFG_ADDR_WIDTH-1:0] i_ConfigAddr,
    input logic [15:0] i_ConfigData,

    output synth_pkg::mix_t o_VoiceSample,
    output synth_pkg::voice_t o_VoiceId,
    output logic o_SampleValid
);

// Sequencer to phase stage
synth_pkg::voice_operator_t w_SeqVoiceOperator;
logic w_SeqValid;

// Decoded register writes
logic w_PhaseStepWriteEnable;
logic w_LevelWriteEnable;
logic [1:0] w_NoteOnWriteEnable;
synth_pkg::voice_operator_t w_ConfigWriteAddr;
logic [15:0] w_ConfigWriteData;

// Phase stage to waveform stage
synth_pkg::phase_t w_Phase;
logic w_NoteOn;
synth_pkg::voice_operator_t w_PhaseVoiceOperator;
logic w_PhaseValid;

// Waveform stage to mixer
synth_pkg::sample_t w_Sample;
synth_pkg::voice_operator_t w_WaveVoiceOperator;
logic w_WaveValid;

operator_sequencer u_sequencer (
    .i_Clock(i_Clock), .i_arst_n(i_arst_n),
    .o_VoiceOperator(w_SeqVoiceOperator), .o_Valid(w_SeqValid)
);

config_write_decoder u_decoder (
    .i_Clock(i_Clock), .i_arst_n(i_arst_n),
    .i_ConfigWrite(i_ConfigWrite), .i_ConfigAddr(i_ConfigAddr),
    .i_ConfigData(i_ConfigData),
    .o_PhaseStepWriteEnable(w_PhaseStepWriteEnable),
    .o_LevelWriteEnable(w_LevelWriteEnable),
    .o_NoteOnWriteEnable(w_NoteOnWriteEnable),
    .o_ConfigWriteAddr(w_ConfigWriteAddr), .o_ConfigWriteData(w_ConfigWriteData)
);

stage_phase_accumulator u_phase (
    .i_Clock(i_Clock), .i_arst_n(i_arst_n), .o_Phase(w_Phase),
    .i_VoiceOperator(w_SeqVoiceOperator), .o_VoiceOperator(w_PhaseVoiceOperator),
    .i_Valid(w_SeqValid), .o_Valid(w_PhaseValid), .o_NoteOn(w_NoteOn),
    .i_NoteOnConfigWriteEnable(w_NoteOnWriteEnable),
    .i_PhaseStepConfigWriteEnable(w_PhaseStepWriteEnable),
    .i_ConfigWriteAddr(w_ConfigWriteAddr), .i_ConfigWriteData(w_ConfigWriteData)
);

stage_waveform u_waveform (
    .i_Clock(i_Clock), .i_arst_n(i_arst_n), .i_Phase(w_Phase), .i_NoteOn(w_NoteOn),
    .i_VoiceOperator(w_PhaseVoiceOperator), .i_Valid(w_PhaseValid),
    .i_LevelWriteEnable(w_LevelWriteEnable), .i_ConfigWriteAddr(w_ConfigWriteAddr),
    .i_ConfigWriteData(w_ConfigWriteData), .o_Sample(w_Sample),
    .o_VoiceOperator(w_WaveVoiceOperator), .o_Valid(w_WaveValid)
);

stage_voice_mixer u_mixer (
    .i_Clock(i_Clock), .i_arst_n(i_arst_n), .i_Sample(w_Sample),
    .i_VoiceOperator(w_WaveVoiceOperator), .i_Valid(w_WaveValid),
    .o_VoiceSample(o_VoiceSample), .o_VoiceId(o_VoiceId), .o_SampleValid(o_SampleValid)
);

endmodule

// File: synth_pkg.sv
`include "synth_cfg.svh"

package synth_pkg;

    // Voice-operator id, voice in bits 6..2 and operator in bits 1..0
    typedef logic `VOICE_OPERATOR_ID voice_operator_t;

    // Voice id, one of 32
    typedef logic [$clog2(`NUM_VOICES)-1:0] voice_t;

    // Unsigned phase, wraps around once per waveform period
    typedef logic [`PHASE_WIDTH-1:0] phase_t;

    // Signed operator sample straight out of the waveform stage
    typedef logic signed [`SAMPLE_WIDTH-1:0] sample_t;

    // Unsigned level, 255 is just under full scale
    typedef logic [`LEVEL_WIDTH-1:0] level_t;

    // Signed sum of the four operators of one voice
    typedef logic signed [`MIX_WIDTH-1:0] mix_t;

    // Drops the operator bits and keeps the voice part of an id
    function automatic voice_t get_voice_id(input voice_operator_t voice_operator);
        return voice_t'(voice_operator >> $clog2(`OPS_PER_VOICE));
    endfunction

endpackage

// File: tb_synth_core.sv
`timescale 1ns/100ps

`include "synth_cfg.svh"

module tb_synth_core;

localparam int NUM_VOICES = `NUM_VOICES;
localparam int OPS = `OPS_PER_VOICE;
localparam int INDEX_SHIFT = `PHASE_WIDTH - `SINE_INDEX_WIDTH;
localparam int SINE_ENTRIES = 1 << `SINE_INDEX_WIDTH;
localparam real PI = 3.141592653589793;

logic i_Clock;
logic i_arst_n;
logic i_ConfigWrite;
logic [`CFG_ADDR_WIDTH-1:0] i_ConfigAddr;
logic [15:0] i_ConfigData;

synth_pkg::mix_t o_VoiceSample;
synth_pkg::voice_t o_VoiceId;
logic o_SampleValid;

// Copy of every register write that the DUT should have taken
int step_model [`NUM_VOICE_OPERATORS];
int level_model [`NUM_VOICE_OPERATORS];
logic [`NUM_VOICES-1:0] note_on_model;

// Per-voice visit count, one visit per voice sample
int visit_count [`NUM_VOICES];
int next_voice;
int pulse_count;
int muted_checked;
int played_checked;

// Cleared while a note-on change is still moving through the pipeline
logic value_check_on;

synth_core UUT (
    .i_Clock(i_Clock), .i_arst_n(i_arst_n),
    .i_ConfigWrite(i_ConfigWrite), .i_ConfigAddr(i_ConfigAddr),
    .i_ConfigData(i_ConfigData),
    .o_VoiceSample(o_VoiceSample), .o_VoiceId(o_VoiceId), .o_SampleValid(o_SampleValid)
);

initial begin
    i_Clock = 1'b0;
    forever #5 i_Clock = ~i_Clock;
end

task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1, "Run stopped");
endtask

task automatic check_value(input string name, input int actual, input int expected);
    if (actual !== expected) begin
        $display("Fail at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
        abort_run("A value did not match the reference");
    end
endtask

// ------------------------------------------------------------
// Reference model of one voice sample
// ------------------------------------------------------------
// The n-th visit of an operator sees n times its step, wrapped at 16 bits
function automatic int ref_voice_sample(input int voice, input int visit);
    int total;
    int op_id;
    longint phase;
    int index;
    int sine;
    int product;
    real angle;
    total = 0;
    if (note_on_model[voice]) begin
        for (int op = 0; op < OPS; op++) begin
            op_id = voice * OPS + op;
            phase = (longint'(visit) * step_model[op_id]) % 65536;
            index = int'(phase >> INDEX_SHIFT);
            angle = 2.0 * PI * real'(index) / real'(SINE_ENTRIES);
            sine = int'(32767.0 * $sin(angle));
            product = sine * level_model[op_id];
            // Arithmetic shift floors toward minus infinity
            total += product >>> 8;
        end
    end
    return total;
endfunction

// Drives one write strobe, called right after a falling edge
task automatic write_register(input logic [`CFG_ADDR_WIDTH-1:0] addr, input logic [15:0] data);
    i_ConfigWrite = 1'b1;
    i_ConfigAddr = addr;
    i_ConfigData = data;
    @(negedge i_Clock);
    i_ConfigWrite = 1'b0;
endtask

task automatic load_config();
    logic [15:0] data;
    for (int id = 0; id < `NUM_VOICE_OPERATORS; id++) begin
        data = 16'($urandom);
        step_model[id] = int'(data);
        write_register({2'b00, 7'(id)}, data);
    end
    for (int id = 0; id < `NUM_VOICE_OPERATORS; id++) begin
        data = 16'($urandom);
        level_model[id] = int'(data[7:0]);
        write_register({2'b01, 7'(id)}, data);
    end
    note_on_model = $urandom;
    // Voice 3 stays muted while voices 0 and 16 play, so the run-time mute
    // of the high word always has a playing voice to silence
    note_on_model[3] = 1'b0;
    note_on_model[0] = 1'b1;
    note_on_model[NUM_VOICES/2] = 1'b1;
    write_register({2'b10, 7'd0}, note_on_model[15:0]);
    write_register({2'b10, 7'd1}, note_on_model[31:16]);
endtask

// Waits until the compare process has seen the given number of pulses
task automatic wait_pulses(input int count);
    int target;
    int limit;
    int cycle;
    target = pulse_count + count;
    limit = count * OPS * 2 + 100;
    for (cycle = 0; cycle < limit; cycle++) begin
        @(negedge i_Clock);
        if (pulse_count >= target)
            return;
    end
    abort_run("Timed out waiting for voice samples from the DUT");
endtask

// ------------------------------------------------------------
// Compare process, samples the outputs mid-cycle
// ------------------------------------------------------------
always @(negedge i_Clock) begin
    int voice;
    int expected;
    if (o_SampleValid) begin
        voice = int'(o_VoiceId);
        // Voices leave in order and wrap after the last one
        check_value("o_VoiceId", voice, next_voice);
        visit_count[voice]++;
        if (value_check_on) begin
            expected = ref_voice_sample(voice, visit_count[voice]);
            check_value("o_VoiceSample", int'(o_VoiceSample), expected);
            if (note_on_model[voice])
                played_checked++;
            else
                muted_checked++;
        end
        next_voice = (next_voice + 1) % NUM_VOICES;
        pulse_count++;
    end
end

initial begin
    void'($urandom(32'ha5bf_2279));
    i_arst_n = 1'b0;
    i_ConfigWrite = 1'b0;
    i_ConfigAddr = '0;
    i_ConfigData = '0;
    value_check_on = 1'b1;
    next_voice = 0;
    pulse_count = 0;
    muted_checked = 0;
    played_checked = 0;
    for (int v = 0; v < NUM_VOICES; v++)
        visit_count[v] = 0;

    repeat (16) @(negedge i_Clock);

    // The sequencer is held, so the whole config loads before any phase moves
    load_config();
    check_value("o_SampleValid", int'(o_SampleValid), 0);
    @(negedge i_Clock);
    i_arst_n = 1'b1;

    // First clock after reset, the pipeline is still filling
    @(negedge i_Clock);
    check_value("o_SampleValid", int'(o_SampleValid), 0);

    // Twenty frames of phase accumulation against the model
    wait_pulses(20 * NUM_VOICES);

    // Mute voices 16 to 31 at run time, skipping the frames in transit
    value_check_on = 1'b0;
    write_register({2'b10, 7'd1}, 16'h0000);
    note_on_model[NUM_VOICES-1:NUM_VOICES/2] = '0;
    wait_pulses(2 * NUM_VOICES);
    value_check_on = 1'b1;
    wait_pulses(4 * NUM_VOICES);

    // Space 11 is unmapped, aimed at an operator of a playing voice
    write_register({2'b11, 7'd0}, 16'($urandom));
    wait_pulses(4 * NUM_VOICES);

    check_value("muted voices checked", int'(muted_checked > 0), 1);
    check_value("playing voices checked", int'(played_checked > 0), 1);

    $display("Finished with no errors");
    $finish;
end

endmodule
